// File: verilog/la32_dec_cfg.svh
`ifndef LA32_DEC_CFG_SVH
`define LA32_DEC_CFG_SVH

// apb address bus width
`define LA32_APB_AW 8

// register byte offsets
`define LA32_REG_INST 8'h00
`define LA32_REG_UOP  8'h04
`define LA32_REG_IMM  8'h08
`define LA32_REG_IDX  8'h0C

// andi r0, r0, 0
`define LA32_INST_NOP 32'h0340_0000

`endif

// File: verilog/la32_dec_pkg.sv
`include "la32_dec_cfg.svh"

package la32_dec_pkg;

    ////////////////////////////////////////////////////////////
    // instruction word views
    typedef struct packed {
        logic [16:0] op;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_reg_fmt_t;

    // hi field sits on top of rj and rd
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] lo;
        logic [9:0]  hi;
    } inst_imm_fmt_t;

    typedef union packed {
        inst_reg_fmt_t reg_fmt;
        inst_imm_fmt_t imm_fmt;
    } inst_u;

    ////////////////////////////////////////////////////////////
    // decode results
    typedef struct packed {
        logic br;
        logic bar;
        logic mem;
        logic csr;
        logic cache;
        logic idle;
        logic eret;
        logic tlb;
        logic mul;
        logic div;
        logic alu;
    } itype_t;

    typedef enum logic [1:0] {SRC1_RF, SRC1_PC, SRC1_ZERO, SRC1_CNTID} src1_e;
    typedef enum logic [1:0] {SRC2_RF, SRC2_IMM, SRC2_CNTL, SRC2_CNTH} src2_e;

    // codes match bits 18:15 of the 3-register alu encodings
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000, ALU_SUB = 4'b0010, ALU_SLT = 4'b0100, ALU_SLTU = 4'b0101,
        ALU_NOR = 4'b1000, ALU_AND = 4'b1001, ALU_OR  = 4'b1010, ALU_XOR  = 4'b1011,
        ALU_SRA = 4'b1101, ALU_SLL = 4'b1110, ALU_SRL = 4'b1111
    } alu_op_e;

    typedef struct packed {
        logic       brk;
        logic       syscall;
        logic       invalid;
        logic       privileged;
        logic       sign;
        src2_e      src2;
        src1_e      src1;
        logic [3:0] cond;
        itype_t     itype;
    } uop_t;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
    } reg_idx_t;

    ////////////////////////////////////////////////////////////
    // apb
    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`LA32_APB_AW-1:0] paddr;
        logic [31:0]             pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// File: verilog/inst_classify.sv
`timescale 1ns/10ps
`include "la32_dec_cfg.svh"

module inst_classify import la32_dec_pkg::*; (
    input  inst_u  inst,
    output uop_t   uop,
    output itype_t itype
);
    logic [31:0] w;
    logic        is_alu, is_sra, is_sfti, is_alu_imm, is_time, is_pcadd, is_lui;
    logic        is_ecall, tlb_inv;
    logic        alu_op_invalid, br_invalid, type_invalid, invalid;
    alu_op_e     alu_op;
    logic [3:0]  cond;
    src1_e       src1;
    src2_e       src2;

    assign w = inst;

    ////////////////////////////////////////////////////////////
    // class detection, bit 31 ignored here
    assign itype.br    = w[30];
    assign itype.bar   = w[30:16] == 15'b011100001110010;
    assign itype.mem   = w[30:28] == 3'b010;
    assign itype.csr   = w[30:24] == 7'b0000100;
    assign itype.cache = w[30:22] == 9'b000011000;
    assign itype.idle  = w[30:15] == 16'b0000110010010001;
    assign itype.eret  = w[30:10] == 21'b000011001001000001110;
    assign itype.mul   = w[30:17] == 14'b00000000001110;
    assign itype.div   = w[30:17] == 14'b00000000010000;

    // invtlb plus the tlbsrch/rd/wr/fill group
    assign tlb_inv   = w[30:15] == 16'b0000110010010011;
    assign itype.tlb = tlb_inv || (w[30:13] == 18'b000011001001000001 && w[12:10] != 3'b110);

    assign is_ecall   = w[30:17] == 14'b00000000010101 && !w[15];
    assign is_alu     = w[30:19] == 12'b000000000010;
    assign is_sra     = w[30:15] == 16'b0000000000110000;
    assign is_sfti    = w[30:20] == 11'b00000000100 && w[17:15] == 3'b001;
    assign is_alu_imm = w[30:25] == 6'b000001;
    assign is_time    = w[30:11] == 20'b00000000000000001100;
    assign is_pcadd   = w[30:25] == 6'b001110;
    assign is_lui     = w[30:25] == 6'b001010;
    assign itype.alu  = is_alu || is_sra || is_sfti || is_alu_imm || is_time || is_pcadd || is_lui;

    ////////////////////////////////////////////////////////////
    // operand sources
    always_comb begin
        if (is_lui) src1 = SRC1_ZERO;
        else if (is_pcadd) src1 = SRC1_PC;
        else if (is_time && !w[10] && w[4:0] == 5'd0) src1 = SRC1_CNTID;
        else src1 = SRC1_RF;
    end

    always_comb begin
        if (is_alu_imm || is_sfti || is_lui || is_pcadd) src2 = SRC2_IMM;
        else if (is_time && !w[10] && w[4:0] != 5'd0) src2 = SRC2_CNTL;
        else if (is_time) src2 = SRC2_CNTH;
        else src2 = SRC2_RF;
    end

    // alu sub-operation
    always_comb begin
        alu_op = ALU_ADD;
        alu_op_invalid = 1'b0;
        if (is_alu) begin
            alu_op = alu_op_e'(w[18:15]);
        end else if (is_alu_imm) begin
            case (w[24:22])
                3'b000:  alu_op = ALU_SLT;
                3'b001:  alu_op = ALU_SLTU;
                3'b010:  alu_op = ALU_ADD;
                3'b101:  alu_op = ALU_AND;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_XOR;
                default: alu_op_invalid = 1'b1;
            endcase
        end else if (is_sfti) begin
            case (w[19:18])
                2'b00:   alu_op = ALU_SLL;
                2'b01:   alu_op = ALU_SRL;
                2'b10:   alu_op = ALU_SRA;
                default: alu_op_invalid = 1'b1;
            endcase
        end else if (is_sra) begin
            alu_op = ALU_SRA;
        end
    end

    // jirl, b, bl and the six compares are the only legal branch codes
    always_comb begin
        case (w[29:26])
            4'b0011, 4'b0100, 4'b0101, 4'b0110,
            4'b0111, 4'b1000, 4'b1001, 4'b1010, 4'b1011: br_invalid = 1'b0;
            default: br_invalid = itype.br;
        endcase
    end

    // classes are exclusive, so priority order does not matter
    always_comb begin
        cond = 4'd0;
        if (itype.alu) cond = alu_op;
        else if (itype.mul) cond = {3'b000, w[15] | w[16]};
        else if (itype.div) cond = {3'b000, w[15]};
        else if (itype.mem) cond = {1'b0, w[24], w[27] ? w[23:22] : 2'b10};
        else if (itype.br) cond = w[29:26];
    end

    ////////////////////////////////////////////////////////////
    // flags and final uop
    assign type_invalid = itype == '0 && !is_ecall;
    assign invalid = alu_op_invalid || type_invalid || br_invalid || w[31];

    always_comb begin
        uop.brk        = is_ecall && !w[16];
        uop.syscall    = is_ecall && w[16];
        uop.invalid    = invalid;
        uop.privileged = itype.cache || itype.tlb || itype.csr || itype.eret || itype.idle;
        // mul/div use bit 16, loads bit 25
        uop.sign       = ((itype.mul || itype.div) && !w[16]) || (itype.mem && !w[25]);
        uop.src2       = src2;
        uop.src1       = src1;
        uop.cond       = cond;
        // nop gets its own all-zero type
        uop.itype      = (w == `LA32_INST_NOP || invalid) ? '0 : itype;
    end

endmodule

// File: verilog/imm_gen.sv
`timescale 1ns/10ps

module imm_gen import la32_dec_pkg::*; (
    input  inst_u       inst,
    input  itype_t      itype,
    output logic [31:0] imm
);
    logic [31:0] w;
    logic        alu_imm, alu_sfti, alu_u20, b_bl;
    logic        is_i12, is_u12, is_i14, is_i16, is_i26, is_i20;

    assign w = inst;

    // sub-classes inside the decoded types
    assign alu_imm  = itype.alu && w[30:25] == 6'b000001;
    assign alu_sfti = itype.alu && w[30:22] == 9'b000000001;
    assign alu_u20  = itype.alu && w[28];
    assign b_bl     = itype.br && w[29:27] == 3'b010;

    // shift amount rides in the i12 field, low 5 bits used
    assign is_i12 = itype.cache || (alu_imm && !w[24]) || (itype.mem && w[27]) || alu_sfti;
    assign is_u12 = alu_imm && w[24];
    // ll/sc and csr
    assign is_i14 = (itype.mem && !w[27]) || itype.csr;
    assign is_i16 = itype.br && !b_bl;
    assign is_i26 = b_bl;
    assign is_i20 = alu_u20;

    always_comb begin
        imm = 32'd0;
        if (is_i12) imm = {{20{w[21]}}, w[21:10]};
        else if (is_u12) imm = {20'd0, w[21:10]};
        else if (is_i14) imm = {{18{w[23]}}, w[23:10]};
        else if (is_i16) imm = {{16{inst.imm_fmt.lo[15]}}, inst.imm_fmt.lo};
        else if (is_i26) imm = {{6{inst.imm_fmt.hi[9]}}, inst.imm_fmt.hi, inst.imm_fmt.lo};
        else if (is_i20) imm = {w[24:5], 12'd0};
    end

endmodule

// File: verilog/reg_index_sel.sv
`timescale 1ns/10ps

module reg_index_sel import la32_dec_pkg::*; (
    input  inst_u    inst,
    input  itype_t   itype,
    output reg_idx_t idx
);
    logic [31:0] w;
    logic        is_bl, is_jirl, b_bl, mem_wr, st_plain, preload, alu_rrr, alu_u20;
    logic        rd_zero, rj_zero, rk_from_rk, rk_from_rd;

    assign w = inst;

    assign is_bl    = itype.br && w[29:26] == 4'b0101;
    assign is_jirl  = itype.br && w[29:26] == 4'b0011;
    assign b_bl     = itype.br && w[29:27] == 3'b010;
    assign mem_wr   = itype.mem && w[24];
    // sc.w still writes its success flag to rd
    assign st_plain = mem_wr && w[27];
    assign preload  = itype.mem && w[27:22] == 6'b101011;
    // 3-register alu and sra.w
    assign alu_rrr  = itype.alu && w[30:21] == 10'd0 && w[20];
    // lu12i.w and pcaddu12i
    assign alu_u20  = itype.alu && w[28];

    assign rd_zero = itype.cache || itype.tlb || itype.idle || preload || st_plain ||
                     (itype.br && !is_jirl && !is_bl);
    assign rj_zero = itype.tlb || itype.idle || alu_u20 || b_bl;

    // store data and compare operand move from rd to rk
    assign rk_from_rk = alu_rrr || itype.mul || itype.div;
    assign rk_from_rd = mem_wr || (itype.br && !b_bl && !is_jirl) || itype.csr;

    always_comb begin
        // bl links through r1
        if (is_bl) idx.rd = 5'd1;
        else if (rd_zero) idx.rd = 5'd0;
        else idx.rd = inst.reg_fmt.rd;

        idx.rj = rj_zero ? 5'd0 : inst.reg_fmt.rj;

        if (rk_from_rk) idx.rk = inst.reg_fmt.rk;
        else if (rk_from_rd) idx.rk = inst.reg_fmt.rd;
        else idx.rk = 5'd0;
    end

endmodule

// File: verilog/decode_apb_ctrl.sv
`timescale 1ns/10ps
`include "la32_dec_cfg.svh"

module decode_apb_ctrl import la32_dec_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output inst_u       inst,
    input  uop_t        uop,
    input  logic [31:0] imm,
    input  reg_idx_t    idx
);
    logic        access, hit_inst, hit_uop, hit_imm, hit_idx, mapped, err, wr_inst;
    logic        load_q;
    inst_u       inst_q;
    uop_t        uop_q;
    logic [31:0] imm_q;
    reg_idx_t    idx_q;
    logic [31:0] rd_word;

    ////////////////////////////////////////////////////////////
    // access decode
    assign access   = apb_req.psel && apb_req.penable;
    assign hit_inst = apb_req.paddr == `LA32_REG_INST;
    assign hit_uop  = apb_req.paddr == `LA32_REG_UOP;
    assign hit_imm  = apb_req.paddr == `LA32_REG_IMM;
    assign hit_idx  = apb_req.paddr == `LA32_REG_IDX;
    assign mapped   = hit_inst || hit_uop || hit_imm || hit_idx;

    // only INST is writable
    assign err     = access && (!mapped || (apb_req.pwrite && !hit_inst));
    assign wr_inst = access && apb_req.pwrite && hit_inst;

    ////////////////////////////////////////////////////////////
    // instruction register and result snapshot
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_q <= '0;
            load_q <= 1'b0;
        end else begin
            load_q <= wr_inst;
            if (wr_inst) inst_q <= apb_req.pwdata;
        end
    end

    assign inst = inst_q;

    // loads one cycle after the write, and through reset so word zero is decoded
    always_ff @(posedge clk) begin
        if (rst || load_q) begin
            uop_q <= uop;
            imm_q <= imm;
            idx_q <= idx;
        end
    end

    ////////////////////////////////////////////////////////////
    // read path
    always_comb begin
        case (apb_req.paddr)
            `LA32_REG_INST: rd_word = inst_q;
            `LA32_REG_UOP:  rd_word = {8'd0, uop_q};
            `LA32_REG_IMM:  rd_word = imm_q;
            `LA32_REG_IDX:  rd_word = {17'd0, idx_q};
            default:        rd_word = 32'd0;
        endcase
    end

    // no wait states
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = err;
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_word : 32'd0;
    end

endmodule

// File: verilog/decode_unit_top.sv
`timescale 1ns/10ps

module decode_unit_top import la32_dec_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);
    inst_u       inst;
    uop_t        uop;
    itype_t      itype;
    logic [31:0] imm;
    reg_idx_t    idx;

    decode_apb_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .inst    (inst),
        .uop     (uop),
        .imm     (imm),
        .idx     (idx)
    );

    inst_classify u_classify (
        .inst  (inst),
        .uop   (uop),
        .itype (itype)
    );

    imm_gen u_imm (
        .inst  (inst),
        .itype (itype),
        .imm   (imm)
    );

    reg_index_sel u_idx (
        .inst  (inst),
        .itype (itype),
        .idx   (idx)
    );

endmodule

// File: test/decode_checker.sv
`timescale 1ns/10ps

module decode_checker import la32_dec_pkg::*; (
    input logic     clk,
    input logic     rst,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp
);
    typedef struct packed {
        logic [31:0] data;
        logic [31:0] mask;
        logic        err;
    } exp_t;

    exp_t  exp_q[$];
    string name_q[$];
    int    error_count = 0;
    int    test_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    checks_done = 0;

    task automatic expect_access(input string name, input logic [31:0] data,
                                 input logic [31:0] mask, input logic err);
        exp_q.push_back({data, mask, err});
        name_q.push_back(name);
    endtask

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // compare each completed access phase
    task automatic check_access();
        exp_t  e;
        string name;
        if (exp_q.size() == 0) begin
            $display("APB access to address %h with no expected result", apb_req.paddr);
            count_error();
        end else begin
            e = exp_q.pop_front();
            name = name_q.pop_front();
            checks_done++;
            if (apb_rsp.pslverr !== e.err) begin
                $display("[ERROR] pslverr got %h expected %h at address %h",
                         apb_rsp.pslverr, e.err, apb_req.paddr);
                count_error();
            end
            // write data is not echoed, only the error flag matters there
            if (!apb_req.pwrite && (apb_rsp.prdata & e.mask) !== (e.data & e.mask)) begin
                $display("[ERROR] %s got %h expected %h", name,
                         apb_rsp.prdata & e.mask, e.data & e.mask);
                count_error();
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && apb_req.psel && apb_req.penable && apb_rsp.pready) check_access();
    end

    task automatic end_test(input string label);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected APB accesses never completed", label, exp_q.size());
            error_count += exp_q.size();
            test_errors += exp_q.size();
            exp_q.delete();
            name_q.delete();
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("pass  %s", label);
        end else begin
            $display("fail  %s", label);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic report();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks_done, error_count);
    endtask

endmodule

// File: test/decode_unit_assert.sv
`timescale 1ns/10ps

module decode_unit_assert import la32_dec_pkg::*; (
    input logic     clk,
    input logic     rst,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input uop_t     uop_q
);
    int fail_count = 0;

    // no wait states
    pready_high: assert property (@(posedge clk) disable iff (rst) apb_rsp.pready)
        else begin
            $error("pready dropped low");
            fail_count++;
        end

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else begin
            $error("pslverr outside an access phase");
            fail_count++;
        end

    invalid_no_type: assert property (@(posedge clk) disable iff (rst)
        uop_q.invalid |-> uop_q.itype == '0)
        else begin
            $error("invalid snapshot carries a nonzero itype");
            fail_count++;
        end

endmodule

bind decode_apb_ctrl decode_unit_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .uop_q   (uop_q)
);

// File: test/decode_unit_tb.sv
`timescale 1ns/10ps
`include "la32_dec_cfg.svh"

module decode_unit_tb import la32_dec_pkg::*; ();
    localparam int NUM_VECS   = 19;
    localparam int WAIT_LIMIT = 20;

    typedef struct packed {
        logic [31:0] word;
        uop_t        uop;
        logic [31:0] imm;
        reg_idx_t    idx;
    } vec_t;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    vec_t        vecs [NUM_VECS];
    logic [31:0] lfsr;

    decode_unit_top uut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    decode_checker chk (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // word, uop, imm, idx
    task automatic load_vectors();
        vecs[0]  = {32'h0010_0823, 24'h000001, 32'h0000_0000, 15'h0C22}; // add.w r3,r1,r2
        vecs[1]  = {32'h0011_1CC5, 24'h001001, 32'h0000_0000, 15'h14C7}; // sub.w r5,r6,r7
        vecs[2]  = {32'h0018_2504, 24'h006801, 32'h0000_0000, 15'h1109}; // sra.w r4,r8,r9
        vecs[3]  = {32'h001C_316A, 24'h080004, 32'h0000_0000, 15'h296C}; // mul.w
        vecs[4]  = {32'h0021_0C41, 24'h000002, 32'h0000_0000, 15'h0443}; // div.wu
        vecs[5]  = {32'h02BF_FC62, 24'h020001, 32'hFFFF_FFFF, 15'h0860}; // addi.w -1
        vecs[6]  = {32'h0360_00A4, 24'h024801, 32'h0000_0800, 15'h10A0}; // andi 0x800
        vecs[7]  = {32'h28BF_E0E6, 24'h081100, 32'hFFFF_FFF8, 15'h18E0}; // ld.w -8
        vecs[8]  = {32'h20FF_F128, 24'h081100, 32'hFFFF_FFFC, 15'h2120}; // ll.w -4
        vecs[9]  = {32'h5BFF_F822, 24'h003400, 32'hFFFF_FFFE, 15'h0022}; // beq r1,r2
        vecs[10] = {32'h53FF_F7FF, 24'h002400, 32'hFFFF_FFFD, 15'h0000}; // b -3
        vecs[11] = {32'h1500_0027, 24'h030001, 32'h8000_1000, 15'h1C00}; // lu12i.w
        vecs[12] = {32'h2980_10C5, 24'h083100, 32'h0000_0004, 15'h00C5}; // st.w
        vecs[13] = {32'h5400_4000, 24'h002C00, 32'h0000_0010, 15'h0400}; // bl
        vecs[14] = {32'h0400_1823, 24'h100080, 32'h0000_0006, 15'h0C23}; // csrwr
        vecs[15] = {`LA32_INST_NOP, 24'h024800, 32'h0000_0000, 15'h0000};
        vecs[16] = {32'h002B_0000, 24'h400000, 32'h0000_0000, 15'h0000}; // syscall
        vecs[17] = {32'h002A_0003, 24'h800000, 32'h0000_0000, 15'h0C00}; // break 3
        vecs[18] = {32'h7000_0000, 24'h206000, 32'h0000_0000, 15'h0000}; // reserved br
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic make_rand_word(output logic [31:0] word);
        int b;
        word = 32'h8000_0000;
        for (b = 0; b < 31; b++) begin
            word[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // apb driver
    task automatic apb_xfer(input logic wr, input logic [`LA32_APB_AW-1:0] addr,
                            input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!apb_rsp.pready) begin
            $display("no pready after %0d cycles on access to address %h", waited, addr);
            $display("Test FAILED");
            $finish;
        end else begin
            @(negedge clk);
            apb_req.psel    = 1'b0;
            apb_req.penable = 1'b0;
            apb_req.pwrite  = 1'b0;
        end
    endtask

    task automatic write_reg(input logic [`LA32_APB_AW-1:0] addr, input logic [31:0] data,
                             input logic err);
        chk.expect_access("pwdata", data, 32'h0, err);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic read_reg(input string name, input logic [`LA32_APB_AW-1:0] addr,
                            input logic [31:0] exp, input logic [31:0] mask, input logic err);
        chk.expect_access(name, exp, mask, err);
        apb_xfer(1'b0, addr, 32'h0);
    endtask

    ////////////////////////////////////////////////////////////
    initial begin
        int          i;
        logic [31:0] word;
        clk = 1'b0;
        rst = 1'b1;
        apb_req = '0;
        lfsr = 32'ha5210857;
        load_vectors();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // snapshot holds the decode of word zero
        read_reg("UOP", `LA32_REG_UOP, 32'h0020_0000, 32'hFFFF_FFFF, 1'b0);
        chk.end_test("reset state");

        for (i = 0; i < NUM_VECS; i++) begin
            write_reg(`LA32_REG_INST, vecs[i].word, 1'b0);
            read_reg("UOP", `LA32_REG_UOP, {8'd0, vecs[i].uop}, 32'hFFFF_FFFF, 1'b0);
            read_reg("IMM", `LA32_REG_IMM, vecs[i].imm, 32'hFFFF_FFFF, 1'b0);
            read_reg("IDX", `LA32_REG_IDX, {17'd0, vecs[i].idx}, 32'hFFFF_FFFF, 1'b0);
            chk.end_test($sformatf("vector %0d inst %h", i, vecs[i].word));
        end

        // bit 31 set, only invalid and itype are predictable
        for (i = 0; i < 16; i++) begin
            make_rand_word(word);
            write_reg(`LA32_REG_INST, word, 1'b0);
            read_reg("UOP", `LA32_REG_UOP, 32'h0020_0000, 32'h0020_07FF, 1'b0);
            chk.end_test($sformatf("random inst %h", word));
        end

        write_reg(`LA32_REG_INST, 32'h0010_0823, 1'b0);
        read_reg("INST", `LA32_REG_INST, 32'h0010_0823, 32'hFFFF_FFFF, 1'b0);
        write_reg(`LA32_REG_UOP, 32'hFFFF_FFFF, 1'b1);
        read_reg("prdata", 8'h20, 32'h0, 32'hFFFF_FFFF, 1'b1);
        read_reg("INST", `LA32_REG_INST, 32'h0010_0823, 32'hFFFF_FFFF, 1'b0);
        chk.end_test("register access and slave errors");

        chk.report();
        if (chk.error_count == 0 && uut.u_ctrl.u_assert.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/la32_dec_pkg.sv
verilog/inst_classify.sv
verilog/imm_gen.sv
verilog/reg_index_sel.sv
verilog/decode_apb_ctrl.sv
verilog/decode_unit_top.sv
test/decode_checker.sv
test/decode_unit_assert.sv
test/decode_unit_tb.sv
